//--- ext_mem.f
+incdir+include
hw/ext_mem_pkg.sv
hw/l1_cache.sv
hw/bus_merge.sv
hw/l2_cache.sv
hw/ext_mem.sv
verif/ext_mem_tb.sv

//--- verif/ext_mem_tb.sv
`timescale 1ns/1ps
`include "ext_mem_consts.svh"

module ext_mem_tb;

   localparam int TIMEOUT  = 200;                   // Cycles per ack wait
   localparam int IC_LINES = 1 << `L1_LINES_W;
   localparam ext_mem_pkg::waddr_t D_BASE = 14'h0200;   // Data range, 96 words
   localparam ext_mem_pkg::waddr_t I_BASE = 14'h1000;   // Instruction range, 48 words

   logic                clk_i = 1'b0;
   logic                arst_i;
   logic                i_req_i;
   ext_mem_pkg::waddr_t i_addr_i;
   ext_mem_pkg::word_t  i_rdata_o;
   logic                i_ack_o;
   logic                d_req_i;
   ext_mem_pkg::waddr_t d_addr_i;
   ext_mem_pkg::word_t  d_wdata_i;
   ext_mem_pkg::strb_t  d_wstrb_i;
   ext_mem_pkg::word_t  d_rdata_o;
   logic                d_ack_o;
   logic                invalidate_i;
   logic                mem_req_o;
   ext_mem_pkg::waddr_t mem_addr_o;
   ext_mem_pkg::word_t  mem_wdata_o;
   ext_mem_pkg::strb_t  mem_wstrb_o;
   ext_mem_pkg::word_t  mem_rdata_i;
   logic                mem_ack_i;

   integer              seed = 32'h41300d79;
   int                  errors = 0;
   int                  checks = 0;
   int                  tests = 0;
   int                  mem_writes = 0;     // Writes seen on the memory bus
   int                  d_writes = 0;       // Writes issued on the data port
   ext_mem_pkg::word_t  mem_store [int];    // External memory
   ext_mem_pkg::word_t  ref_mem [int];      // Expected memory contents
   ext_mem_pkg::word_t  ic_data [IC_LINES]; // Icache copy, predicts stale hits
   ext_mem_pkg::waddr_t ic_addr [IC_LINES];
   logic [IC_LINES-1:0] ic_valid = '0;

   ext_mem ext_mem_i (.*);

   always #10 clk_i = ~clk_i;

   // Power-up word built from every address bit
   function automatic ext_mem_pkg::word_t init_word(input int a);
      return {a[13:0], 4'ha, ~a[13:0]};
   endfunction

   function automatic ext_mem_pkg::word_t apply_strobes(input ext_mem_pkg::word_t old_w,
         input ext_mem_pkg::word_t new_w, input ext_mem_pkg::strb_t strb);
      ext_mem_pkg::word_t w;
      w = old_w;
      for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
         if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];   // Byte lane b
      end
      return w;
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic give_up(input string port);
      $display("timeout: %s did not ack within %0d cycles", port, TIMEOUT);
      $display(">>> FAIL");
      $finish;
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %0d %s finished, errors so far %0d", tests, name, errors);
   endtask

   // Memory side, random 0 to 5 cycle latency
   initial begin
      int lat;
      mem_ack_i   = 1'b0;
      mem_rdata_i = '0;
      forever begin
         @(posedge clk_i);
         #1;
         if (mem_req_o) begin
            lat = $unsigned($random(seed)) % 6;
            #(20 * lat);   // Stays 1 ns past the edge
            if (mem_wstrb_o != '0) begin
               mem_writes++;
               check("mem_addr_o", mem_addr_o, d_addr_i);   // Only the data port writes
               check("mem_wdata_o", mem_wdata_o, d_wdata_i);
               check("mem_wstrb_o", mem_wstrb_o, d_wstrb_i);
               mem_store[mem_addr_o] = apply_strobes(mem_store[mem_addr_o], mem_wdata_o,
                                                     mem_wstrb_o);
            end
            mem_rdata_i = mem_store[mem_addr_o];
            mem_ack_i   = 1'b1;
            @(posedge clk_i);
            #1;
            mem_ack_i   = 1'b0;   // One-cycle pulse
            mem_rdata_i = '0;
         end
      end
   end

   // Data port access, zero strobe reads
   task automatic data_op(input ext_mem_pkg::waddr_t a, input ext_mem_pkg::word_t wd,
                          input ext_mem_pkg::strb_t strb);
      int n;
      int writes_before;
      n             = 0;
      writes_before = mem_writes;
      d_req_i       = 1'b1;
      d_addr_i      = a;
      d_wdata_i     = wd;
      d_wstrb_i     = strb;
      do begin
         @(posedge clk_i);
         #1;
         n++;
      end while (!d_ack_o && n < TIMEOUT);
      if (!d_ack_o) begin
         give_up("data port");
      end else begin
         d_req_i   = 1'b0;
         d_wstrb_i = '0;
         if (strb != '0) begin
            d_writes++;
            ref_mem[a] = apply_strobes(ref_mem[a], wd, strb);
            check("mem writes for one data write", mem_writes - writes_before, 1);
         end else begin
            check("d_rdata_o", d_rdata_o, ref_mem[a]);
         end
      end
   endtask

   task automatic random_data_op();
      ext_mem_pkg::waddr_t a;
      ext_mem_pkg::word_t  wd;
      ext_mem_pkg::strb_t  strb;
      a    = D_BASE + $unsigned($random(seed)) % 96;   // Conflicts in the 64-line L1
      wd   = $random(seed);
      strb = $random(seed);
      if ($random(seed) & 1) strb = '0;   // About half reads
      data_op(a, wd, strb);
   endtask

   task automatic instr_read(input ext_mem_pkg::waddr_t a, output ext_mem_pkg::word_t got);
      int                 n;
      int                 idx;
      ext_mem_pkg::word_t exp;
      n   = 0;
      idx = a[`L1_LINES_W-1:0];
      if (ic_valid[idx] && ic_addr[idx] == a) exp = ic_data[idx];   // Hit, maybe stale
      else exp = ref_mem[a];                                        // Miss sees memory
      i_req_i  = 1'b1;
      i_addr_i = a;
      do begin
         @(posedge clk_i);
         #1;
         n++;
      end while (!i_ack_o && n < TIMEOUT);
      if (!i_ack_o) begin
         give_up("instruction port");
      end else begin
         i_req_i = 1'b0;
         check("i_rdata_o", i_rdata_o, exp);
         ic_valid[idx] = 1'b1;
         ic_addr[idx]  = a;
         ic_data[idx]  = exp;
         got           = i_rdata_o;
      end
   endtask

   task automatic pulse_invalidate();
      invalidate_i = 1'b1;
      @(posedge clk_i);
      #1;
      invalidate_i = 1'b0;
      ic_valid     = '0;   // Whole icache gone
   endtask

   initial begin
      ext_mem_pkg::word_t  old_w;
      ext_mem_pkg::word_t  new_w;
      ext_mem_pkg::word_t  got;
      ext_mem_pkg::waddr_t ia;
      arst_i       = 1'b1;
      i_req_i      = 1'b0;
      i_addr_i     = '0;
      d_req_i      = 1'b0;
      d_addr_i     = '0;
      d_wdata_i    = '0;
      d_wstrb_i    = '0;
      invalidate_i = 1'b0;
      for (int a = 0; a < (1 << `EXT_MEM_ADDR_W); a++) begin
         mem_store[a] = init_word(a);
         ref_mem[a]   = init_word(a);
      end
      for (int c = 0; c < 8; c++) begin   // Five cycles in reset, three after
         @(posedge clk_i);
         #1;
         check("i_ack_o after reset", i_ack_o, 0);
         check("d_ack_o after reset", d_ack_o, 0);
         check("mem_req_o after reset", mem_req_o, 0);
         if (c == 4) arst_i = 1'b0;
      end
      finish_test("reset");
      repeat (200) random_data_op();
      finish_test("data reads and writes");
      check("mem writes against data writes", mem_writes, d_writes);
      finish_test("write-through");
      repeat (150) instr_read(I_BASE + $unsigned($random(seed)) % 48, got);
      finish_test("instruction reads");
      repeat (100) begin
         ia = I_BASE + $unsigned($random(seed)) % 48;
         fork   // Both ports start in the same cycle
            random_data_op();
            instr_read(ia, got);
         join
      end
      finish_test("concurrent ports");
      old_w = ref_mem[I_BASE + 5];   // Word the icache is about to hold
      new_w = ~old_w;
      instr_read(I_BASE + 5, got);
      data_op(I_BASE + 5, new_w, 4'hf);
      instr_read(I_BASE + 5, got);
      check("stale icache word", got, old_w);
      pulse_invalidate();
      instr_read(I_BASE + 5, got);
      check("word after invalidate", got, new_w);
      finish_test("stale data and invalidate");
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- hw/ext_mem.sv
`timescale 1ns/1ps
`include "ext_mem_consts.svh"

module ext_mem (
   input  logic                clk_i,
   input  logic                arst_i,
   // Instruction port, read only
   input  logic                i_req_i,
   input  ext_mem_pkg::waddr_t i_addr_i,
   output ext_mem_pkg::word_t  i_rdata_o,
   output logic                i_ack_o,
   // Data port
   input  logic                d_req_i,
   input  ext_mem_pkg::waddr_t d_addr_i,
   input  ext_mem_pkg::word_t  d_wdata_i,
   input  ext_mem_pkg::strb_t  d_wstrb_i,
   output ext_mem_pkg::word_t  d_rdata_o,
   output logic                d_ack_o,
   input  logic                invalidate_i,   // Clears all caches
   // Memory bus
   output logic                mem_req_o,
   output ext_mem_pkg::waddr_t mem_addr_o,
   output ext_mem_pkg::word_t  mem_wdata_o,
   output ext_mem_pkg::strb_t  mem_wstrb_o,
   input  ext_mem_pkg::word_t  mem_rdata_i,
   input  logic                mem_ack_i
);

   // Instruction cache never writes
   ext_mem_pkg::strb_t  i_wstrb_zero = '0;

   logic                ic_be_req,  dc_be_req,  l2_req;
   ext_mem_pkg::waddr_t ic_be_addr, dc_be_addr, l2_addr;
   ext_mem_pkg::word_t  ic_be_wdata, dc_be_wdata, l2_wdata;
   ext_mem_pkg::strb_t  ic_be_wstrb, dc_be_wstrb, l2_wstrb;
   ext_mem_pkg::word_t  ic_be_rdata, dc_be_rdata, l2_rdata;
   logic                ic_be_ack,  dc_be_ack,  l2_ack;

   l1_cache #(.LINES_W(`L1_LINES_W)) icache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(i_req_i), .addr_i(i_addr_i), .wdata_i('0), .wstrb_i(i_wstrb_zero),
      .rdata_o(i_rdata_o), .ack_o(i_ack_o), .invalidate_i(invalidate_i),
      .be_req_o(ic_be_req), .be_addr_o(ic_be_addr), .be_wdata_o(ic_be_wdata),
      .be_wstrb_o(ic_be_wstrb), .be_rdata_i(ic_be_rdata), .be_ack_i(ic_be_ack)
   );

   l1_cache #(.LINES_W(`L1_LINES_W)) dcache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(d_req_i), .addr_i(d_addr_i), .wdata_i(d_wdata_i), .wstrb_i(d_wstrb_i),
      .rdata_o(d_rdata_o), .ack_o(d_ack_o), .invalidate_i(invalidate_i),
      .be_req_o(dc_be_req), .be_addr_o(dc_be_addr), .be_wdata_o(dc_be_wdata),
      .be_wstrb_o(dc_be_wstrb), .be_rdata_i(dc_be_rdata), .be_ack_i(dc_be_ack)
   );

   // Icache is master 0 and wins ties
   bus_merge merge_i_d (
      .clk_i(clk_i), .arst_i(arst_i),
      .m0_req_i(ic_be_req), .m0_addr_i(ic_be_addr), .m0_wdata_i(ic_be_wdata),
      .m0_wstrb_i(ic_be_wstrb), .m0_rdata_o(ic_be_rdata), .m0_ack_o(ic_be_ack),
      .m1_req_i(dc_be_req), .m1_addr_i(dc_be_addr), .m1_wdata_i(dc_be_wdata),
      .m1_wstrb_i(dc_be_wstrb), .m1_rdata_o(dc_be_rdata), .m1_ack_o(dc_be_ack),
      .s_req_o(l2_req), .s_addr_o(l2_addr), .s_wdata_o(l2_wdata),
      .s_wstrb_o(l2_wstrb), .s_rdata_i(l2_rdata), .s_ack_i(l2_ack)
   );

   l2_cache #(.LINES_W(`L2_LINES_W)) l2cache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(l2_req), .addr_i(l2_addr), .wdata_i(l2_wdata), .wstrb_i(l2_wstrb),
      .rdata_o(l2_rdata), .ack_o(l2_ack), .invalidate_i(invalidate_i),
      .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
      .mem_wstrb_o(mem_wstrb_o), .mem_rdata_i(mem_rdata_i), .mem_ack_i(mem_ack_i)
   );

endmodule

//--- hw/l2_cache.sv
`timescale 1ns/1ps
`include "ext_mem_consts.svh"

module l2_cache #(
   parameter int LINES_W = `L2_LINES_W   // log2 of line count
) (
   input  logic                clk_i,
   input  logic                arst_i,
   // Front end, from the merge
   input  logic                req_i,
   input  ext_mem_pkg::waddr_t addr_i,
   input  ext_mem_pkg::word_t  wdata_i,
   input  ext_mem_pkg::strb_t  wstrb_i,
   output ext_mem_pkg::word_t  rdata_o,
   output logic                ack_o,
   input  logic                invalidate_i,
   // Memory bus
   output logic                mem_req_o,
   output ext_mem_pkg::waddr_t mem_addr_o,
   output ext_mem_pkg::word_t  mem_wdata_o,
   output ext_mem_pkg::strb_t  mem_wstrb_o,
   input  ext_mem_pkg::word_t  mem_rdata_i,
   input  logic                mem_ack_i
);

   localparam int LINES = 1 << LINES_W;
   localparam int TAG_W = `EXT_MEM_ADDR_W - LINES_W;

   ext_mem_pkg::cache_state_t state_q;
   logic [LINES-1:0]          valid_q;
   logic [TAG_W-1:0]          tag_mem [LINES];
   ext_mem_pkg::word_t        data_mem [LINES];
   ext_mem_pkg::word_t        rdata_q;
   logic                      ack_q;
   logic                      inv_pend_q;   // Invalidate waiting for an idle bus

   logic [LINES_W-1:0]        idx;
   logic [TAG_W-1:0]          tag;
   logic                      hit;
   logic                      is_write;
   logic                      accept;
   logic                      fill;
   logic                      wr_hit;
   logic                      inv_now;
   ext_mem_pkg::word_t        merged;

   assign idx      = addr_i[LINES_W-1:0];
   assign tag      = addr_i[`EXT_MEM_ADDR_W-1:LINES_W];
   assign hit      = valid_q[idx] && (tag_mem[idx] == tag);
   assign is_write = |wstrb_i;
   assign accept   = req_i && !ack_q && (state_q == ext_mem_pkg::cache_idle);
   assign fill     = mem_ack_i && (state_q == ext_mem_pkg::cache_read_miss);
   assign wr_hit   = mem_ack_i && (state_q == ext_mem_pkg::cache_write_through) && hit;
   assign inv_now  = inv_pend_q && !req_i;   // Never clears under a live request

   // Byte merge for write hits
   always_comb begin
      merged = data_mem[idx];
      for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
         if (wstrb_i[b]) begin
            merged[8*b +: 8] = wdata_i[8*b +: 8];
         end
      end
   end

   // Pending invalidate, armed by the pulse
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         inv_pend_q <= 1'b0;
      end else if (invalidate_i) begin
         inv_pend_q <= 1'b1;
      end else if (!req_i) begin
         inv_pend_q <= 1'b0;
      end
   end

   // Controller
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= ext_mem_pkg::cache_idle;
         ack_q   <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         case (state_q)
            ext_mem_pkg::cache_idle: begin
               if (accept) begin
                  if (is_write) state_q <= ext_mem_pkg::cache_write_through;
                  else if (!hit) state_q <= ext_mem_pkg::cache_read_miss;
                  else ack_q <= 1'b1;   // Hit
               end
            end
            ext_mem_pkg::cache_read_miss,
            ext_mem_pkg::cache_write_through: begin
               if (mem_ack_i) begin   // Memory may stall as long as it likes
                  ack_q   <= 1'b1;
                  state_q <= ext_mem_pkg::cache_idle;
               end
            end
            default: state_q <= ext_mem_pkg::cache_idle;
         endcase
      end
   end

   // Valid bits
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else if (inv_now) begin
         valid_q <= '0;
      end else if (fill) begin
         valid_q[idx] <= 1'b1;
      end
   end

   // Arrays
   always_ff @(posedge clk_i) begin
      if (fill) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= mem_rdata_i;
      end else if (wr_hit) begin
         data_mem[idx] <= merged;
      end
   end

   // Read data register
   always_ff @(posedge clk_i) begin
      if (accept && hit) rdata_q <= data_mem[idx];
      else if (fill) rdata_q <= mem_rdata_i;
   end

   assign rdata_o = rdata_q;
   assign ack_o   = ack_q;

   // Memory bus, request held from the front end
   assign mem_req_o   = (state_q != ext_mem_pkg::cache_idle);
   assign mem_addr_o  = addr_i;
   assign mem_wdata_o = wdata_i;
   assign mem_wstrb_o = (state_q == ext_mem_pkg::cache_write_through) ? wstrb_i : '0;

endmodule

//--- hw/bus_merge.sv
`timescale 1ns/1ps

module bus_merge (
   input  logic                clk_i,
   input  logic                arst_i,
   // Master 0, instruction cache
   input  logic                m0_req_i,
   input  ext_mem_pkg::waddr_t m0_addr_i,
   input  ext_mem_pkg::word_t  m0_wdata_i,
   input  ext_mem_pkg::strb_t  m0_wstrb_i,
   output ext_mem_pkg::word_t  m0_rdata_o,
   output logic                m0_ack_o,
   // Master 1, data cache
   input  logic                m1_req_i,
   input  ext_mem_pkg::waddr_t m1_addr_i,
   input  ext_mem_pkg::word_t  m1_wdata_i,
   input  ext_mem_pkg::strb_t  m1_wstrb_i,
   output ext_mem_pkg::word_t  m1_rdata_o,
   output logic                m1_ack_o,
   // Slave
   output logic                s_req_o,
   output ext_mem_pkg::waddr_t s_addr_o,
   output ext_mem_pkg::word_t  s_wdata_o,
   output ext_mem_pkg::strb_t  s_wstrb_o,
   input  ext_mem_pkg::word_t  s_rdata_i,
   input  logic                s_ack_i
);

   ext_mem_pkg::merge_state_t grant_q;
   logic                      sel_d;   // Data master owns the slave

   // Grant from idle, held until the slave acks
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         grant_q <= ext_mem_pkg::merge_idle;
      end else begin
         case (grant_q)
            ext_mem_pkg::merge_idle: begin
               if (m0_req_i) grant_q <= ext_mem_pkg::merge_grant_i;   // Fixed priority
               else if (m1_req_i) grant_q <= ext_mem_pkg::merge_grant_d;
            end
            ext_mem_pkg::merge_grant_i,
            ext_mem_pkg::merge_grant_d: begin
               if (s_ack_i) grant_q <= ext_mem_pkg::merge_idle;
            end
            default: grant_q <= ext_mem_pkg::merge_idle;
         endcase
      end
   end

   assign sel_d = (grant_q == ext_mem_pkg::merge_grant_d);

   // Slave side muxed by grant
   assign s_req_o   = (grant_q != ext_mem_pkg::merge_idle);
   assign s_addr_o  = sel_d ? m1_addr_i  : m0_addr_i;
   assign s_wdata_o = sel_d ? m1_wdata_i : m0_wdata_i;
   assign s_wstrb_o = sel_d ? m1_wstrb_i : m0_wstrb_i;

   // Response only reaches the granted master
   assign m0_ack_o   = s_ack_i && (grant_q == ext_mem_pkg::merge_grant_i);
   assign m1_ack_o   = s_ack_i && sel_d;
   assign m0_rdata_o = (grant_q == ext_mem_pkg::merge_grant_i) ? s_rdata_i : '0;
   assign m1_rdata_o = sel_d ? s_rdata_i : '0;

endmodule

//--- hw/l1_cache.sv
`timescale 1ns/1ps
`include "ext_mem_consts.svh"

module l1_cache #(
   parameter int LINES_W = `L1_LINES_W   // log2 of line count
) (
   input  logic                clk_i,
   input  logic                arst_i,
   // Front end
   input  logic                req_i,
   input  ext_mem_pkg::waddr_t addr_i,
   input  ext_mem_pkg::word_t  wdata_i,
   input  ext_mem_pkg::strb_t  wstrb_i,
   output ext_mem_pkg::word_t  rdata_o,
   output logic                ack_o,
   input  logic                invalidate_i,
   // Back end
   output logic                be_req_o,
   output ext_mem_pkg::waddr_t be_addr_o,
   output ext_mem_pkg::word_t  be_wdata_o,
   output ext_mem_pkg::strb_t  be_wstrb_o,
   input  ext_mem_pkg::word_t  be_rdata_i,
   input  logic                be_ack_i
);

   localparam int LINES = 1 << LINES_W;
   localparam int TAG_W = `EXT_MEM_ADDR_W - LINES_W;

   ext_mem_pkg::cache_state_t state_q;
   logic [LINES-1:0]          valid_q;
   logic [TAG_W-1:0]          tag_mem [LINES];
   ext_mem_pkg::word_t        data_mem [LINES];
   ext_mem_pkg::word_t        rdata_q;      // Registered read data
   logic                      ack_q;

   logic [LINES_W-1:0]        idx;
   logic [TAG_W-1:0]          tag;
   logic                      hit;
   logic                      is_write;
   logic                      accept;
   logic                      fill;
   logic                      wr_hit;
   ext_mem_pkg::word_t        merged;

   assign idx      = addr_i[LINES_W-1:0];                  // Low bits pick the line
   assign tag      = addr_i[`EXT_MEM_ADDR_W-1:LINES_W];
   assign hit      = valid_q[idx] && (tag_mem[idx] == tag);
   assign is_write = |wstrb_i;                             // Nonzero strobe means write
   // Request still high in the ack cycle must not be taken twice
   assign accept   = req_i && !ack_q && (state_q == ext_mem_pkg::cache_idle);
   assign fill     = be_ack_i && (state_q == ext_mem_pkg::cache_read_miss);
   assign wr_hit   = be_ack_i && (state_q == ext_mem_pkg::cache_write_through) && hit;

   // Stored word with the written bytes replaced
   always_comb begin
      merged = data_mem[idx];
      for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
         if (wstrb_i[b]) begin
            merged[8*b +: 8] = wdata_i[8*b +: 8];
         end
      end
   end

   // Controller
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= ext_mem_pkg::cache_idle;
         ack_q   <= 1'b0;
      end else begin
         ack_q <= 1'b0;   // Single-cycle pulse
         case (state_q)
            ext_mem_pkg::cache_idle: begin
               if (accept) begin
                  if (is_write) begin
                     state_q <= ext_mem_pkg::cache_write_through;
                  end else if (!hit) begin
                     state_q <= ext_mem_pkg::cache_read_miss;
                  end else begin
                     ack_q <= 1'b1;   // Read hit, answered locally
                  end
               end
            end
            ext_mem_pkg::cache_read_miss,
            ext_mem_pkg::cache_write_through: begin
               if (be_ack_i) begin
                  ack_q   <= 1'b1;
                  state_q <= ext_mem_pkg::cache_idle;
               end
            end
            default: state_q <= ext_mem_pkg::cache_idle;
         endcase
      end
   end

   // Valid bits, invalidate wins over a fill in the same cycle
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (fill) begin
         valid_q[idx] <= 1'b1;
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk_i) begin
      if (fill) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= be_rdata_i;
      end else if (wr_hit) begin
         data_mem[idx] <= merged;   // Keep line coherent with what went down
      end
   end

   // Read data for the ack cycle
   always_ff @(posedge clk_i) begin
      if (accept && hit) begin
         rdata_q <= data_mem[idx];
      end else if (fill) begin
         rdata_q <= be_rdata_i;
      end
   end

   assign rdata_o = rdata_q;
   assign ack_o   = ack_q;

   // Back end carries the held front-end request
   assign be_req_o   = (state_q != ext_mem_pkg::cache_idle);
   assign be_addr_o  = addr_i;
   assign be_wdata_o = wdata_i;
   assign be_wstrb_o = (state_q == ext_mem_pkg::cache_write_through) ? wstrb_i : '0;

endmodule

//--- hw/ext_mem_pkg.sv
`include "ext_mem_consts.svh"

package ext_mem_pkg;

   // Vectors shared by every bus in the subsystem
   typedef logic [`EXT_MEM_DATA_W-1:0] word_t;
   typedef logic [`EXT_MEM_STRB_W-1:0] strb_t;
   typedef logic [`EXT_MEM_ADDR_W-1:0] waddr_t;

   // Cache controller states, same for both levels
   typedef enum logic [1:0] {
      cache_idle,
      cache_read_miss,       // Waiting on back-end fill
      cache_write_through    // Waiting on back-end write
   } cache_state_t;

   // Arbiter grant
   typedef enum logic [1:0] {
      merge_idle,
      merge_grant_i,         // Master 0, instruction side
      merge_grant_d          // Master 1, data side
   } merge_state_t;

endpackage

//--- include/ext_mem_consts.svh
`ifndef EXT_MEM_CONSTS_SVH
`define EXT_MEM_CONSTS_SVH

// Bus widths
`define EXT_MEM_DATA_W 32   // Data word
`define EXT_MEM_ADDR_W 14   // Word address, not byte address
`define EXT_MEM_STRB_W 4    // One strobe per byte

// Cache geometry, one word per line
`define L1_LINES_W 6        // 64 lines in each level-one cache
`define L2_LINES_W 8        // 256 lines in the shared level-two cache

`endif
